//--- list.f
hdl/romload_pkg.sv
hdl/rom_slot_if.sv
hdl/dwnld_formatter.sv
hdl/rom_slot.sv
hdl/rom_arbiter.sv
hdl/rom_subsys_top.sv
tests/tb_sdram_model.sv
tests/tb_rom_subsys.sv

//--- run.sh
#!/usr/bin/env bash
# Build the ROM subsystem testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --assert -Wno-fatal --top-module tb_rom_subsys \
    -f list.f -o tb_rom_subsys > "$build_log" 2>&1
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status, see $build_log"
    exit 1
fi

./obj_dir/tb_rom_subsys > "$sim_log" 2>&1
sim_status=$?
cat "$sim_log"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Result: PASSED" "$sim_log"; then
    echo "Simulation passed"
    exit 0
fi

echo "Pass message not found in $sim_log"
exit 1

//--- tests/tb_rom_subsys.sv
module tb_rom_subsys
    import romload_pkg::*;
();

    localparam sdram_addr_t SCR_OFFSET  = sdram_addr_t'(SCR_START >> 1);
    localparam sdram_addr_t OBJ_OFFSET  = sdram_addr_t'(OBJ_START >> 1);
    localparam sdram_addr_t MAIN_OFFSET = '0;
    localparam int SCR_AW  = 13;
    localparam int OBJ_AW  = 13;
    localparam int MAIN_AW = 14;

    // Whole 16 and 32 word blocks so every graphics word gets written
    localparam int MAIN_BYTES = 64;
    localparam int SCR_BYTES  = 64;
    localparam int OBJ_BYTES  = 128;
    localparam int PROM_BYTES = 16;
    localparam int N_READS    = 20;
    localparam int N_ROUNDS   = 10;
    localparam int N_TRANSFERS = MAIN_BYTES + SCR_BYTES + OBJ_BYTES + PROM_BYTES + 3
                               + N_READS * 5 + N_ROUNDS * 5;
    localparam int TIMEOUT_CYCLES = N_TRANSFERS * 20 + 300;

    logic              clk;
    logic              reset;
    logic              downloading;
    ioctl_addr_t       ioctl_addr;
    byte_t             ioctl_dout;
    logic              ioctl_wr;
    logic              ioctl_ready;
    sdram_addr_t       prog_addr;
    byte_t             prog_data;
    logic [1:0]        prog_mask;
    logic              prog_we;
    logic              prog_ack;
    prom_addr_t        prom_addr;
    byte_t             prom_data;
    logic              prom_we;
    logic              variant;
    logic              sdram_req;
    sdram_addr_t       sdram_addr;
    logic              sdram_ack;
    logic              data_rdy;
    sdram_word_t       data_read;
    logic              scr_cs;
    logic [SCR_AW-1:0] scr_addr;
    logic [31:0]       scr_data;
    logic              scr_ok;
    logic              obj_cs;
    logic [OBJ_AW-1:0] obj_addr;
    logic [31:0]       obj_data;
    logic              obj_ok;
    logic              main_cs;
    logic [MAIN_AW-1:0] main_addr;
    byte_t             main_data;
    logic              main_ok;

    // Reference model, indexed by word address times two plus lane
    byte_t       ref_bytes [int];
    sdram_addr_t exp_addr_q[$];
    logic [1:0]  exp_mask_q[$];
    byte_t       exp_data_q[$];
    prom_addr_t  exp_prom_addr_q[$];
    byte_t       exp_prom_data_q[$];
    logic [31:0] rng_state = 32'd87;

    rom_subsys_top #(
        .SCR_OFFSET (SCR_OFFSET),
        .OBJ_OFFSET (OBJ_OFFSET),
        .MAIN_OFFSET(MAIN_OFFSET),
        .SCR_AW     (SCR_AW),
        .OBJ_AW     (OBJ_AW),
        .MAIN_AW    (MAIN_AW)
    ) u_dut (.*);

    tb_sdram_model #(.SEED(32'd87)) u_mem (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Result: FAILED");
        $fatal(1, "Watchdog expired");
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int rand_below(input int n);
        rng_state = xorshift(rng_state);
        return int'(rng_state % 32'(n));
    endfunction

    // Scroll and object words get their low address bits reordered
    function automatic sdram_addr_t map_word(input ioctl_addr_t a);
        sdram_addr_t w;
        sdram_addr_t m;
        w = sdram_addr_t'(a >> 1);
        m = w;
        if (a >= OBJ_START && a < PCM_START) begin
            m[4] = w[2];
            m[3] = w[1];
            m[2] = w[0];
            m[1] = ~w[4];
            m[0] = ~w[3];
        end else if (a >= SCR_START && a < OBJ_START) begin
            m[3] = w[2];
            m[2] = w[1];
            m[1] = w[0];
            m[0] = ~w[3];
        end
        return m;
    endfunction

    function automatic sdram_word_t ref_word(input sdram_addr_t w);
        return {ref_bytes[int'(w) * 2 + 1], ref_bytes[int'(w) * 2]};
    endfunction

    task automatic stop_run();
        $display("Result: FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_word(input sdram_word_t got, input sdram_word_t exp, input string what);
        if (got !== exp) begin
            $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_byte(input byte_t got, input byte_t exp, input string what);
        if (got !== exp) begin
            $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_addr(input sdram_addr_t got, input sdram_addr_t exp, input string what);
        if (got !== exp) begin
            $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_mask(input logic [1:0] got, input logic [1:0] exp, input string what);
        if (got !== exp) begin
            $display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_prom_addr(input prom_addr_t got, input prom_addr_t exp, input string what);
        if (got !== exp) begin
            $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    // Memory and PROM side, checked as each write completes
    always @(posedge clk) begin
        if (!reset) begin
            if (downloading) begin
                check_flag(sdram_req, 1'b0, "sdram_req while downloading");
            end
            if (prog_we && prog_ack && exp_addr_q.size() == 0) begin
                $display("A write was acknowledged at %0t with no byte sent for it", $time);
                stop_run();
            end else if (prog_we && prog_ack) begin
                check_addr(prog_addr, exp_addr_q.pop_front(), "prog_addr");
                check_mask(prog_mask, exp_mask_q.pop_front(), "prog_mask");
                check_byte(prog_data, exp_data_q.pop_front(), "prog_data");
            end
            if (prom_we && exp_prom_addr_q.size() == 0) begin
                $display("prom_we pulsed at %0t with no PROM byte sent", $time);
                stop_run();
            end else if (prom_we) begin
                check_prom_addr(prom_addr, exp_prom_addr_q.pop_front(), "prom_addr");
                check_byte(prom_data, exp_prom_data_q.pop_front(), "prom_data");
            end
        end
    end

    task automatic send_byte(input ioctl_addr_t a, input byte_t d);
        sdram_addr_t w;
        @(negedge clk);
        while (!ioctl_ready) begin
            @(negedge clk);
        end
        if (a >= PROM_START) begin
            exp_prom_addr_q.push_back(prom_addr_t'(a - PROM_START));
            exp_prom_data_q.push_back(d);
        end else begin
            w = map_word(a);
            exp_addr_q.push_back(w);
            exp_mask_q.push_back(a[0] ? 2'b10 : 2'b01);
            exp_data_q.push_back(d);
            // Even bytes sit in the upper half of the word
            ref_bytes[int'(w) * 2 + (a[0] ? 0 : 1)] = d;
        end
        ioctl_addr = a;
        ioctl_dout = d;
        ioctl_wr   = 1'b1;
        @(negedge clk);
        ioctl_wr = 1'b0;
    endtask

    task automatic send_block(input ioctl_addr_t start, input int count);
        for (int i = 0; i < count; i++) begin
            send_byte(start + ioctl_addr_t'(i), byte_t'(rand_below(256)));
        end
    endtask

    task automatic read_scr(input int n);
        sdram_addr_t w;
        @(negedge clk);
        scr_cs   = 1'b1;
        scr_addr = SCR_AW'(n);
        @(negedge clk);
        while (!scr_ok) begin
            @(negedge clk);
        end
        w = SCR_OFFSET + sdram_addr_t'(2 * n);
        check_word(scr_data[15:0], ref_word(w), "scroll low word");
        check_word(scr_data[31:16], ref_word(w + 1'b1), "scroll high word");
    endtask

    task automatic read_obj(input int n);
        sdram_addr_t w;
        @(negedge clk);
        obj_cs   = 1'b1;
        obj_addr = OBJ_AW'(n);
        @(negedge clk);
        while (!obj_ok) begin
            @(negedge clk);
        end
        w = OBJ_OFFSET + sdram_addr_t'(2 * n);
        check_word(obj_data[15:0], ref_word(w), "object low word");
        check_word(obj_data[31:16], ref_word(w + 1'b1), "object high word");
    endtask

    task automatic read_main(input int n);
        sdram_word_t w;
        @(negedge clk);
        main_cs   = 1'b1;
        main_addr = MAIN_AW'(n);
        @(negedge clk);
        while (!main_ok) begin
            @(negedge clk);
        end
        w = ref_word(MAIN_OFFSET + sdram_addr_t'(n));
        check_byte(main_data, w[7:0], "main byte");
    endtask

    initial begin
        int a_scr, a_obj, a_main;
        int d_scr, d_obj, d_main;
        reset       = 1'b1;
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_dout  = '0;
        ioctl_wr    = 1'b0;
        scr_cs      = 1'b0;
        scr_addr    = '0;
        obj_cs      = 1'b0;
        obj_addr    = '0;
        main_cs     = 1'b0;
        main_addr   = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_flag(ioctl_ready, 1'b1, "ioctl_ready after reset");
        check_flag(sdram_req | prog_we | prom_we | variant, 1'b0, "outputs after reset");
        check_flag(scr_ok | obj_ok | main_ok, 1'b0, "ok after reset");

        // A scroll read waits until the download is over
        downloading = 1'b1;
        scr_cs      = 1'b1;
        send_block(ioctl_addr_t'(0), MAIN_BYTES);
        send_block(SCR_START, SCR_BYTES);
        send_block(OBJ_START, OBJ_BYTES);
        for (int i = 0; i < PROM_BYTES; i++) begin
            send_byte(PROM_START + ioctl_addr_t'(i), (i == 1) ? 8'hff : byte_t'(rand_below(256)));
            check_flag(ioctl_ready, 1'b1, "ioctl_ready after a PROM byte");
            if (i == 1) begin
                check_flag(variant, 1'b1, "variant after an all-ones byte");
            end
        end
        send_byte(PROM_START + 1'b1, byte_t'(rand_below(256)) & 8'hfe);
        check_flag(variant, 1'b0, "variant after another byte");
        while (prog_we || exp_addr_q.size() != 0 || exp_prom_addr_q.size() != 0) begin
            @(negedge clk);
        end
        downloading = 1'b0;

        read_scr(0);
        for (int i = 0; i < N_READS; i++) begin
            read_scr(rand_below(SCR_BYTES / 4));
            read_obj(rand_below(OBJ_BYTES / 4));
        end
        for (int i = 0; i < N_READS; i++) begin
            read_main(rand_below(MAIN_BYTES / 2));
        end

        // All three slots compete, then the same addresses again
        for (int r = 0; r < N_ROUNDS; r++) begin
            a_scr  = rand_below(SCR_BYTES / 4);
            a_obj  = rand_below(OBJ_BYTES / 4);
            a_main = rand_below(MAIN_BYTES / 2);
            d_scr  = rand_below(4);
            d_obj  = rand_below(4);
            d_main = rand_below(4);
            fork
                begin
                    repeat (d_scr) @(negedge clk);
                    read_scr(a_scr);
                end
                begin
                    repeat (d_obj) @(negedge clk);
                    read_obj(a_obj);
                end
                begin
                    repeat (d_main) @(negedge clk);
                    read_main(a_main);
                end
            join
            @(negedge clk);
            scr_cs  = 1'b0;
            obj_cs  = 1'b0;
            main_cs = 1'b0;
            @(negedge clk);
            scr_cs  = 1'b1;
            obj_cs  = 1'b1;
            main_cs = 1'b1;
            @(negedge clk);
            check_flag(scr_ok && obj_ok && main_ok, 1'b1, "ok on a repeated address");
            // A refetch would reach sdram_req within two cycles
            repeat (3) begin
                @(negedge clk);
                check_flag(sdram_req, 1'b0, "sdram_req on a repeated address");
            end
        end

        repeat (5) @(negedge clk);
        $display("Result: PASSED");
        $finish;
    end

endmodule

//--- tests/tb_sdram_model.sv
module tb_sdram_model
    import romload_pkg::*;
#(
    parameter logic [31:0] SEED = 32'd87
) (
    input  logic        clk,
    input  logic        reset,
    // Loader writes
    input  sdram_addr_t prog_addr,
    input  byte_t       prog_data,
    input  logic [1:0]  prog_mask,
    input  logic        prog_we,
    output logic        prog_ack,
    // Read port
    input  logic        sdram_req,
    input  sdram_addr_t sdram_addr,
    output logic        sdram_ack,
    output logic        data_rdy,
    output sdram_word_t data_read
);

    sdram_word_t mem [sdram_addr_t];
    logic [31:0] rng = SEED;
    int          wr_wait = -1;
    int          req_wait = -1;
    int          data_wait = -1;
    sdram_addr_t rd_addr;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Words never written read back a pattern of their own address
    function automatic sdram_word_t read_word(input sdram_addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return a[15:0] ^ {10'd0, a[21:16]};
    endfunction

    initial begin
        prog_ack  = 1'b0;
        sdram_ack = 1'b0;
        data_rdy  = 1'b0;
        data_read = '0;
    end

    // Outputs change on the falling edge, all pulses last one cycle
    always @(negedge clk) begin
        prog_ack  <= 1'b0;
        sdram_ack <= 1'b0;
        data_rdy  <= 1'b0;
        if (reset) begin
            wr_wait   = -1;
            req_wait  = -1;
            data_wait = -1;
        end else begin
            if (prog_we && !prog_ack) begin
                if (wr_wait < 0) begin
                    rng     = xorshift(rng);
                    wr_wait = int'(rng % 4);
                end
                if (wr_wait == 0) begin
                    prog_ack <= 1'b1;
                end
                wr_wait = wr_wait - 1;
            end
            // Read taken at the last edge, data follows 1 to 4 cycles later
            if (sdram_ack) begin
                rng       = xorshift(rng);
                data_wait = int'(rng % 4);
            end
            if (data_wait >= 0) begin
                if (data_wait == 0) begin
                    data_rdy  <= 1'b1;
                    data_read <= read_word(rd_addr);
                end
                data_wait = data_wait - 1;
            end else if (sdram_req && !sdram_ack) begin
                if (req_wait < 0) begin
                    rng      = xorshift(rng);
                    req_wait = int'(rng % 4);
                end
                if (req_wait == 0) begin
                    sdram_ack <= 1'b1;
                    rd_addr   = sdram_addr;
                end
                req_wait = req_wait - 1;
            end
        end
    end

    always @(posedge clk) begin
        sdram_word_t w;
        if (!reset && prog_we && prog_ack) begin
            w = read_word(prog_addr);
            // Mask bits are active low, bit 1 is the upper lane
            if (!prog_mask[1]) begin
                w[15:8] = prog_data;
            end
            if (!prog_mask[0]) begin
                w[7:0] = prog_data;
            end
            mem[prog_addr] = w;
        end
    end

endmodule

//--- hdl/rom_subsys_top.sv
module rom_subsys_top
    import romload_pkg::*;
#(
    parameter sdram_addr_t SCR_OFFSET  = sdram_addr_t'(SCR_START >> 1),
    parameter sdram_addr_t OBJ_OFFSET  = sdram_addr_t'(OBJ_START >> 1),
    parameter sdram_addr_t MAIN_OFFSET = '0,
    parameter int          SCR_AW      = 13,
    parameter int          OBJ_AW      = 13,
    parameter int          MAIN_AW     = 14
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               downloading,
    // Loader
    input  ioctl_addr_t        ioctl_addr,
    input  byte_t              ioctl_dout,
    input  logic               ioctl_wr,
    output logic               ioctl_ready,
    output sdram_addr_t        prog_addr,
    output byte_t              prog_data,
    output logic [1:0]         prog_mask,
    output logic               prog_we,
    input  logic               prog_ack,
    output prom_addr_t         prom_addr,
    output byte_t              prom_data,
    output logic               prom_we,
    output logic               variant,
    // SDRAM read port
    output logic               sdram_req,
    output sdram_addr_t        sdram_addr,
    input  logic               sdram_ack,
    input  logic               data_rdy,
    input  sdram_word_t        data_read,
    // Scroll graphics
    input  logic               scr_cs,
    input  logic [SCR_AW-1:0]  scr_addr,
    output logic [31:0]        scr_data,
    output logic               scr_ok,
    // Object graphics
    input  logic               obj_cs,
    input  logic [OBJ_AW-1:0]  obj_addr,
    output logic [31:0]        obj_data,
    output logic               obj_ok,
    // Main CPU
    input  logic               main_cs,
    input  logic [MAIN_AW-1:0] main_addr,
    output byte_t              main_data,
    output logic               main_ok
);

    rom_slot_if scr_if ();
    rom_slot_if obj_if ();
    rom_slot_if main_if ();

    sdram_word_t main_word;

    // Main CPU code sits in the low byte of each word
    assign main_data = main_word[7:0];

    dwnld_formatter u_dwnld (
        .clk         (clk),
        .reset       (reset),
        .downloading (downloading),
        .ioctl_addr  (ioctl_addr),
        .ioctl_dout  (ioctl_dout),
        .ioctl_wr    (ioctl_wr),
        .ioctl_ready (ioctl_ready),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .prog_mask   (prog_mask),
        .prog_we     (prog_we),
        .prog_ack    (prog_ack),
        .prom_addr   (prom_addr),
        .prom_data   (prom_data),
        .prom_we     (prom_we),
        .variant     (variant)
    );

    rom_slot #(.AW(SCR_AW), .DW(32), .OFFSET(SCR_OFFSET)) u_scr (
        .clk (clk), .reset (reset), .cs (scr_cs), .addr (scr_addr),
        .data (scr_data), .ok (scr_ok), .mem (scr_if.slot)
    );

    rom_slot #(.AW(OBJ_AW), .DW(32), .OFFSET(OBJ_OFFSET)) u_obj (
        .clk (clk), .reset (reset), .cs (obj_cs), .addr (obj_addr),
        .data (obj_data), .ok (obj_ok), .mem (obj_if.slot)
    );

    rom_slot #(.AW(MAIN_AW), .DW(16), .OFFSET(MAIN_OFFSET)) u_main (
        .clk (clk), .reset (reset), .cs (main_cs), .addr (main_addr),
        .data (main_word), .ok (main_ok), .mem (main_if.slot)
    );

    rom_arbiter u_arb (
        .clk         (clk),
        .reset       (reset),
        .downloading (downloading),
        .s0          (scr_if.arb),
        .s1          (obj_if.arb),
        .s2          (main_if.arb),
        .sdram_req   (sdram_req),
        .sdram_addr  (sdram_addr),
        .sdram_ack   (sdram_ack),
        .data_rdy    (data_rdy),
        .data_read   (data_read)
    );

endmodule

//--- hdl/rom_arbiter.sv
module rom_arbiter
    import romload_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        downloading,
    rom_slot_if.arb     s0,
    rom_slot_if.arb     s1,
    rom_slot_if.arb     s2,
    // SDRAM read port
    output logic        sdram_req,
    output sdram_addr_t sdram_addr,
    input  logic        sdram_ack,
    input  logic        data_rdy,
    input  sdram_word_t data_read
);

    arb_state_t  state;
    logic [1:0]  owner;
    logic [1:0]  grant;
    logic        any_req;
    sdram_addr_t grant_addr;
    logic        ack_pulse;
    logic        rdy_pulse;

    assign any_req = s0.req || s1.req || s2.req;

    // Fixed priority, slot 0 first
    always_comb begin
        if (s0.req) begin
            grant      = 2'd0;
            grant_addr = s0.addr;
        end else if (s1.req) begin
            grant      = 2'd1;
            grant_addr = s1.addr;
        end else begin
            grant      = 2'd2;
            grant_addr = s2.addr;
        end
    end

    assign ack_pulse = (state == ARB_WAIT_ACK) && sdram_ack;
    assign rdy_pulse = (state == ARB_WAIT_DATA) && data_rdy;

    // Only the owner sees the handshake pulses
    assign s0.ack = ack_pulse && (owner == 2'd0);
    assign s1.ack = ack_pulse && (owner == 2'd1);
    assign s2.ack = ack_pulse && (owner == 2'd2);
    assign s0.rdy = rdy_pulse && (owner == 2'd0);
    assign s1.rdy = rdy_pulse && (owner == 2'd1);
    assign s2.rdy = rdy_pulse && (owner == 2'd2);

    assign s0.data = data_read;
    assign s1.data = data_read;
    assign s2.data = data_read;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= ARB_IDLE;
            sdram_req <= 1'b0;
            owner     <= 2'd0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (any_req && !downloading) begin
                        owner     <= grant;
                        sdram_req <= 1'b1;
                        state     <= ARB_WAIT_ACK;
                    end
                end
                ARB_WAIT_ACK: begin
                    // Stalls here for as long as the memory is busy
                    if (sdram_ack) begin
                        sdram_req <= 1'b0;
                        state     <= ARB_WAIT_DATA;
                    end
                end
                ARB_WAIT_DATA: begin
                    if (data_rdy) begin
                        state <= ARB_IDLE;
                    end
                end
                default: begin
                    state <= ARB_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ARB_IDLE && any_req && !downloading) begin
            sdram_addr <= grant_addr;
        end
    end

    no_data_when_idle: assert property (
        @(posedge clk) disable iff (reset)
        data_rdy |-> state != ARB_IDLE
    ) else $error("data_rdy with no read outstanding");

endmodule

//--- hdl/rom_slot.sv
module rom_slot
    import romload_pkg::*;
#(
    parameter int          AW     = 13,
    parameter int          DW     = 32,
    parameter sdram_addr_t OFFSET = '0
) (
    input  logic          clk,
    input  logic          reset,
    input  logic          cs,
    input  logic [AW-1:0] addr,
    output logic [DW-1:0] data,
    output logic          ok,
    rom_slot_if.slot      mem
);

    localparam int BEATS = DW / 16;

    logic [AW-1:0] addr_q;
    logic [DW-1:0] data_q;
    logic          valid;
    logic          fetching;
    logic          req_q;
    logic          beat;
    logic          hit;
    logic          last_beat;
    sdram_addr_t   word_idx;

    assign hit       = valid && (addr == addr_q);
    assign ok        = cs && hit;
    assign data      = data_q;
    assign last_beat = (beat == 1'(BEATS - 1));

    // Wide slots read two consecutive words per entry
    assign word_idx = (DW == 32) ? sdram_addr_t'({addr_q, beat}) : sdram_addr_t'(addr_q);
    assign mem.addr = OFFSET + word_idx;
    assign mem.req  = req_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid    <= 1'b0;
            fetching <= 1'b0;
            req_q    <= 1'b0;
            beat     <= 1'b0;
        end else if (!fetching) begin
            if (cs && !hit) begin
                fetching <= 1'b1;
                req_q    <= 1'b1;
                beat     <= 1'b0;
                valid    <= 1'b0;
            end
        end else begin
            if (mem.ack) begin
                req_q <= 1'b0;
            end
            if (mem.rdy) begin
                if (cs && addr != addr_q) begin
                    // Address moved on, drop this fetch and miss again
                    fetching <= 1'b0;
                end else if (last_beat) begin
                    fetching <= 1'b0;
                    valid    <= 1'b1;
                end else begin
                    beat  <= beat + 1'b1;
                    req_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!fetching && cs && !hit) begin
            addr_q <= addr;
        end
        if (fetching && mem.rdy) begin
            // First word fills the low half
            data_q[beat*16 +: 16] <= mem.data;
        end
    end

    rdy_only_when_pending: assert property (
        @(posedge clk) disable iff (reset)
        mem.rdy |-> fetching && !req_q
    ) else $error("rdy without a pending fetch");

endmodule

//--- hdl/dwnld_formatter.sv
module dwnld_formatter
    import romload_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        downloading,
    // Loader byte stream
    input  ioctl_addr_t ioctl_addr,
    input  byte_t       ioctl_dout,
    input  logic        ioctl_wr,
    output logic        ioctl_ready,
    // SDRAM write port
    output sdram_addr_t prog_addr,
    output byte_t       prog_data,
    output logic [1:0]  prog_mask,
    output logic        prog_we,
    input  logic        prog_ack,
    // Colour PROM write
    output prom_addr_t  prom_addr,
    output byte_t       prom_data,
    output logic        prom_we,
    output logic        variant
);

    // The second PROM byte tells the board variants apart
    localparam ioctl_addr_t VARIANT_ADDR = PROM_START + ioctl_addr_t'(1);

    region_t     region;
    sdram_addr_t word_addr;
    sdram_addr_t mapped_addr;
    ioctl_addr_t prom_offset;
    logic        accept;

    assign accept      = ioctl_wr && ioctl_ready && downloading;
    assign region      = get_region(ioctl_addr);
    assign word_addr   = ioctl_addr[22:1];
    assign prom_offset = ioctl_addr - PROM_START;

    // Graphics ROMs are stored with their low address bits rotated
    always_comb begin
        mapped_addr = word_addr;
        case (region)
            REG_SCR: begin
                mapped_addr[3:0] = {word_addr[2:0], ~word_addr[3]};
            end
            REG_OBJ: begin
                mapped_addr[4:0] = {word_addr[2:0], ~word_addr[4], ~word_addr[3]};
            end
            default: begin
                mapped_addr = word_addr;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ioctl_ready <= 1'b1;
            prog_we     <= 1'b0;
            prom_we     <= 1'b0;
            variant     <= 1'b0;
        end else begin
            prom_we <= 1'b0;
            if (prog_we && prog_ack) begin
                prog_we     <= 1'b0;
                ioctl_ready <= 1'b1;
            end
            if (accept) begin
                if (region == REG_PROM) begin
                    // PROM bytes never stall the loader
                    prom_we <= 1'b1;
                end else begin
                    prog_we     <= 1'b1;
                    ioctl_ready <= 1'b0;
                end
                if (ioctl_addr == VARIANT_ADDR) begin
                    variant <= &ioctl_dout;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            if (region == REG_PROM) begin
                prom_addr <= prom_offset[10:0];
                prom_data <= ioctl_dout;
            end else begin
                prog_addr <= mapped_addr;
                prog_data <= ioctl_dout;
                // Even bytes land in the upper lane, mask is active low
                prog_mask <= {ioctl_addr[0], ~ioctl_addr[0]};
            end
        end
    end

    // Write must not move while the memory has not taken it
    prog_addr_stable: assert property (
        @(posedge clk) disable iff (reset)
        prog_we && !prog_ack |=> prog_we && $stable(prog_addr)
    ) else $error("prog_addr changed before prog_ack");

endmodule

//--- hdl/rom_slot_if.sv
interface rom_slot_if import romload_pkg::*; ();

    // Read request from the slot, held until ack
    logic        req;
    sdram_addr_t addr;

    // Pulses from the arbiter
    logic        ack;
    logic        rdy;
    sdram_word_t data;

    modport slot (
        output req,
        output addr,
        input  ack,
        input  rdy,
        input  data
    );

    modport arb (
        input  req,
        input  addr,
        output ack,
        output rdy,
        output data
    );

endinterface

//--- hdl/romload_pkg.sv
package romload_pkg;

    // Loader byte address, as seen on the ioctl bus
    typedef logic [24:0] ioctl_addr_t;

    // SDRAM is addressed in 16-bit words
    typedef logic [21:0] sdram_addr_t;
    typedef logic [15:0] sdram_word_t;

    typedef logic [7:0]  byte_t;

    // Colour PROMs, 2 kB in total
    typedef logic [10:0] prom_addr_t;

    // Region starts, in loader byte addresses
    localparam ioctl_addr_t SCR_START  = 25'h0_8000;
    localparam ioctl_addr_t OBJ_START  = 25'h1_0000;
    localparam ioctl_addr_t PCM_START  = 25'h1_8000;
    localparam ioctl_addr_t PROM_START = 25'h2_0000;

    typedef enum logic [2:0] {
        REG_MAIN,
        REG_SCR,
        REG_OBJ,
        REG_OTHER,
        REG_PROM
    } region_t;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_WAIT_ACK,
        ARB_WAIT_DATA
    } arb_state_t;

    // Regions are checked from the top down, so each test
    // only needs the lower bound
    function automatic region_t get_region(ioctl_addr_t a);
        region_t r;
        if (a >= PROM_START) begin
            r = REG_PROM;
        end else if (a >= PCM_START) begin
            r = REG_OTHER;
        end else if (a >= OBJ_START) begin
            r = REG_OBJ;
        end else if (a >= SCR_START) begin
            r = REG_SCR;
        end else begin
            r = REG_MAIN;
        end
        return r;
    endfunction

endpackage
